// File: rtl/usb_bridge_pkg.sv
// usb command bridge definitions
package usb_bridge_pkg;

  // ---------------------------------------------------------------------------
  // slave fifo bus geometry
  // ---------------------------------------------------------------------------
  localparam int WORD_W      = 32;
  localparam int HALF_W      = 16;
  localparam int FIFO_ADDR_W = 2;

  // endpoint select codes on faddr
  localparam logic [FIFO_ADDR_W-1:0] OUT_EP_ADDR = 2'd3;
  localparam logic [FIFO_ADDR_W-1:0] IN_EP_ADDR  = 2'd0;

  // ---------------------------------------------------------------------------
  // buffering
  // ---------------------------------------------------------------------------
  localparam int DOWN_DEPTH  = 16;
  localparam int UP_DEPTH    = 16;
  // free slots needed before a read starts, one word may still be in flight
  localparam int DOWN_MARGIN = 2;
  // occupancy and free count width, covers depths up to 31
  localparam int COUNT_W     = 5;

  // 2 s at 100 MHz before the block ram copy comes alive
  localparam int unsigned HOLDOFF_CYCLES = 200_000_000;

  // ---------------------------------------------------------------------------
  // shared types
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } word_strobe_t;

  // flag a and flag b, active high
  typedef struct packed {
    logic out_ready;
    logic in_ready;
  } fx3_flags_t;

  // all strobes active low
  typedef struct packed {
    logic                   slcs_n;
    logic                   sloe_n;
    logic                   slrd_n;
    logic                   slwr_n;
    logic                   pktend_n;
    logic [FIFO_ADDR_W-1:0] faddr;
  } fx3_ctrl_t;

  typedef enum logic [2:0] {
    IDLE,
    RD_SELECT,
    RD_STROBE,
    RD_WAIT,
    RD_CAPTURE,
    WR_SELECT,
    WR_STROBE,
    WR_PKTEND
  } fx3_state_e;

endpackage

// File: rtl/word_fifo.sv
// synchronous word fifo
module word_fifo #(
  parameter int depth = usb_bridge_pkg::DOWN_DEPTH
) (
  input  logic                               clk_100,
  input  logic                               reset,
  input  logic                               wr_en,
  input  logic [usb_bridge_pkg::WORD_W-1:0]  wr_data,
  input  logic                               rd_en,
  output logic [usb_bridge_pkg::WORD_W-1:0]  rd_data,
  output logic                               rd_valid,
  output logic                               empty,
  output logic [usb_bridge_pkg::COUNT_W-1:0] free_count
);

  // word storage
  logic [usb_bridge_pkg::WORD_W-1:0] mem [depth];

  logic [$clog2(depth)-1:0]          wr_ptr;
  logic [$clog2(depth)-1:0]          rd_ptr;
  logic [usb_bridge_pkg::COUNT_W-1:0] count;
  logic                              full;
  logic                              wr_ok;
  logic                              rd_ok;

  assign full  = (count == depth[usb_bridge_pkg::COUNT_W-1:0]);
  assign empty = (count == '0);

  // writes on full and reads on empty fall on the floor
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  assign free_count = depth[usb_bridge_pkg::COUNT_W-1:0] - count;

  // ---------------------------------------------------------------------------
  // pointers and occupancy
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_100) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        // explicit wrap for any depth
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves count alone
      if (wr_ok && !rd_ok) begin
        count <= count + 1'b1;
      end else if (rd_ok && !wr_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  // array write
  always_ff @(posedge clk_100) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ---------------------------------------------------------------------------
  // registered read port
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_100) begin
    if (rd_ok) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // one cycle after an accepted read
  always_ff @(posedge clk_100) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_ok;
    end
  end

endmodule

// File: rtl/fx3_slave_fifo.sv
// fx3 slave fifo interface controller
module fx3_slave_fifo (
  input  logic                               clk_100,
  input  logic                               reset,
  input  usb_bridge_pkg::fx3_flags_t         flags,
  input  logic [usb_bridge_pkg::COUNT_W-1:0] down_free,
  input  logic                               up_empty,
  input  usb_bridge_pkg::word_strobe_t       up_word,
  output usb_bridge_pkg::fx3_ctrl_t          ctrl,
  output usb_bridge_pkg::word_strobe_t       down_word,
  output logic                               up_rd,
  inout  wire  [usb_bridge_pkg::WORD_W-1:0]  fdata
);

  usb_bridge_pkg::fx3_state_e        state;
  usb_bridge_pkg::fx3_state_e        state_nxt;

  // set after a read so the next tie goes to the write side
  logic                              prefer_wr;
  logic                              rd_req;
  logic                              wr_req;
  logic                              start_rd;
  logic                              start_wr;

  // upload word held for the length of the write
  logic [usb_bridge_pkg::WORD_W-1:0] wr_word;
  logic [usb_bridge_pkg::WORD_W-1:0] wr_out;
  logic                              drive_en;

  // ---------------------------------------------------------------------------
  // arbitration
  // ---------------------------------------------------------------------------
  // read needs data in the OUT endpoint and room for the word
  assign rd_req = flags.out_ready && (down_free >= usb_bridge_pkg::DOWN_MARGIN);
  // write needs a pending word and space on the IN side
  assign wr_req = flags.in_ready && !up_empty;

  assign start_rd = rd_req && (!wr_req || !prefer_wr);
  assign start_wr = wr_req && !start_rd;

  // fetch from the upload fifo on the way out of idle
  assign up_rd = (state == usb_bridge_pkg::IDLE) && start_wr;

  always_ff @(posedge clk_100) begin
    if (reset) begin
      prefer_wr <= 1'b0;
    end else if (state == usb_bridge_pkg::IDLE) begin
      if (start_rd) begin
        prefer_wr <= 1'b1;
      end else if (start_wr) begin
        prefer_wr <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // state machine
  // ---------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      usb_bridge_pkg::IDLE: begin
        if (start_rd) begin
          state_nxt = usb_bridge_pkg::RD_SELECT;
        end else if (start_wr) begin
          state_nxt = usb_bridge_pkg::WR_SELECT;
        end
      end
      usb_bridge_pkg::RD_SELECT:  state_nxt = usb_bridge_pkg::RD_STROBE;
      usb_bridge_pkg::RD_STROBE:  state_nxt = usb_bridge_pkg::RD_WAIT;
      // host has two edges to put the word out
      usb_bridge_pkg::RD_WAIT:    state_nxt = usb_bridge_pkg::RD_CAPTURE;
      usb_bridge_pkg::RD_CAPTURE: state_nxt = usb_bridge_pkg::IDLE;
      usb_bridge_pkg::WR_SELECT: begin
        // hold the word on the bus until the IN side has room
        if (flags.in_ready) begin
          state_nxt = usb_bridge_pkg::WR_STROBE;
        end
      end
      usb_bridge_pkg::WR_STROBE: begin
        // nothing left to send, commit the packet
        if (up_empty) begin
          state_nxt = usb_bridge_pkg::WR_PKTEND;
        end else begin
          state_nxt = usb_bridge_pkg::IDLE;
        end
      end
      usb_bridge_pkg::WR_PKTEND:  state_nxt = usb_bridge_pkg::IDLE;
      default:                    state_nxt = usb_bridge_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_100) begin
    if (reset) begin
      state <= usb_bridge_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ---------------------------------------------------------------------------
  // pin strobes, decoded from state
  // ---------------------------------------------------------------------------
  always_comb begin
    ctrl.slcs_n   = 1'b1;
    ctrl.sloe_n   = 1'b1;
    ctrl.slrd_n   = 1'b1;
    ctrl.slwr_n   = 1'b1;
    ctrl.pktend_n = 1'b1;
    // park on the OUT endpoint
    ctrl.faddr    = usb_bridge_pkg::OUT_EP_ADDR;
    case (state)
      usb_bridge_pkg::RD_SELECT,
      usb_bridge_pkg::RD_WAIT,
      usb_bridge_pkg::RD_CAPTURE: begin
        ctrl.slcs_n = 1'b0;
        ctrl.sloe_n = 1'b0;
      end
      usb_bridge_pkg::RD_STROBE: begin
        ctrl.slcs_n = 1'b0;
        ctrl.sloe_n = 1'b0;
        ctrl.slrd_n = 1'b0;
      end
      usb_bridge_pkg::WR_SELECT: begin
        ctrl.slcs_n = 1'b0;
        ctrl.faddr  = usb_bridge_pkg::IN_EP_ADDR;
      end
      usb_bridge_pkg::WR_STROBE: begin
        ctrl.slcs_n = 1'b0;
        ctrl.slwr_n = 1'b0;
        ctrl.faddr  = usb_bridge_pkg::IN_EP_ADDR;
      end
      usb_bridge_pkg::WR_PKTEND: begin
        ctrl.slcs_n   = 1'b0;
        ctrl.pktend_n = 1'b0;
        ctrl.faddr    = usb_bridge_pkg::IN_EP_ADDR;
      end
      default: begin
      end
    endcase
  end

  // ---------------------------------------------------------------------------
  // data path
  // ---------------------------------------------------------------------------
  // upload word arrives in the first cycle of WR_SELECT
  always_ff @(posedge clk_100) begin
    if (up_word.valid) begin
      wr_word <= up_word.data;
    end
  end

  assign wr_out = up_word.valid ? up_word.data : wr_word;

  // bus only driven while a word is going out
  assign drive_en = (state == usb_bridge_pkg::WR_SELECT) ||
                    (state == usb_bridge_pkg::WR_STROBE);
  assign fdata    = drive_en ? wr_out : 'z;

  // capture at the end of RD_CAPTURE, fifo write follows a cycle later
  always_ff @(posedge clk_100) begin
    if (reset) begin
      down_word.valid <= 1'b0;
    end else begin
      down_word.valid <= (state == usb_bridge_pkg::RD_CAPTURE);
    end
  end

  always_ff @(posedge clk_100) begin
    if (state == usb_bridge_pkg::RD_CAPTURE) begin
      down_word.data <= fdata;
    end
  end

endmodule

// File: rtl/cmd_dispatch.sv
// command dispatcher
module cmd_dispatch #(
  parameter int unsigned hold_cycles = usb_bridge_pkg::HOLDOFF_CYCLES
) (
  input  logic                         clk_100,
  input  logic                         reset,
  input  logic                         fifo_empty,
  input  usb_bridge_pkg::word_strobe_t fifo_word,
  output logic                         fifo_rd,
  output usb_bridge_pkg::word_strobe_t cmd,
  output usb_bridge_pkg::word_strobe_t bram
);

  // start-up hold-off, saturates at hold_cycles
  logic [$clog2(hold_cycles+1)-1:0] hold_cnt;
  logic                             hold_done;

  // ---------------------------------------------------------------------------
  // command path
  // ---------------------------------------------------------------------------
  // drain as soon as anything is buffered
  assign fifo_rd = !fifo_empty;

  // fifo read data already registered, strobe is its data-valid
  assign cmd = fifo_word;

  // ---------------------------------------------------------------------------
  // hold-off counter
  // ---------------------------------------------------------------------------
  assign hold_done = (hold_cnt >= hold_cycles);

  always_ff @(posedge clk_100) begin
    if (reset) begin
      hold_cnt <= '0;
    end else if (!hold_done) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // block ram copy
  // ---------------------------------------------------------------------------
  // one cycle behind cmd, halves exchanged
  // forced to zero while the hold-off runs
  always_ff @(posedge clk_100) begin
    if (reset || !hold_done) begin
      bram <= '0;
    end else begin
      bram.valid <= fifo_word.valid;
      // low half goes up, high half goes down
      bram.data  <= {fifo_word.data[usb_bridge_pkg::HALF_W-1:0],
                     fifo_word.data[usb_bridge_pkg::WORD_W-1:usb_bridge_pkg::HALF_W]};
    end
  end

endmodule

// File: rtl/usb_cmd_bridge.sv
// usb 3.0 command bridge top
module usb_cmd_bridge #(
  parameter int unsigned hold_cycles = usb_bridge_pkg::HOLDOFF_CYCLES
) (
  input  logic                              clk_100,
  input  logic                              reset,
  input  usb_bridge_pkg::fx3_flags_t        flags,
  output usb_bridge_pkg::fx3_ctrl_t         ctrl,
  inout  wire [usb_bridge_pkg::WORD_W-1:0]  fdata,
  input  usb_bridge_pkg::word_strobe_t      feedback,
  output usb_bridge_pkg::word_strobe_t      cmd,
  output usb_bridge_pkg::word_strobe_t      bram
);

  // host to device path
  usb_bridge_pkg::word_strobe_t       down_word;
  logic [usb_bridge_pkg::COUNT_W-1:0] down_free;
  logic [usb_bridge_pkg::WORD_W-1:0]  down_data;
  logic                               down_valid;
  logic                               down_empty;
  logic                               down_rd;

  // device to host path
  logic [usb_bridge_pkg::WORD_W-1:0]  up_data;
  logic                               up_valid;
  logic                               up_empty;
  logic                               up_rd;

  // ---------------------------------------------------------------------------
  // slave fifo pins
  // ---------------------------------------------------------------------------
  fx3_slave_fifo u_slave_fifo (
    .clk_100   (clk_100),
    .reset     (reset),
    .flags     (flags),
    .down_free (down_free),
    .up_empty  (up_empty),
    .up_word   ({up_valid, up_data}),
    .ctrl      (ctrl),
    .down_word (down_word),
    .up_rd     (up_rd),
    .fdata     (fdata)
  );

  // ---------------------------------------------------------------------------
  // buffers
  // ---------------------------------------------------------------------------
  // commands from the OUT endpoint
  word_fifo #(.depth(usb_bridge_pkg::DOWN_DEPTH)) u_down_fifo (
    .clk_100    (clk_100),
    .reset      (reset),
    .wr_en      (down_word.valid),
    .wr_data    (down_word.data),
    .rd_en      (down_rd),
    .rd_data    (down_data),
    .rd_valid   (down_valid),
    .empty      (down_empty),
    .free_count (down_free)
  );

  // feedback toward the IN endpoint, overflow is dropped
  word_fifo #(.depth(usb_bridge_pkg::UP_DEPTH)) u_up_fifo (
    .clk_100    (clk_100),
    .reset      (reset),
    .wr_en      (feedback.valid),
    .wr_data    (feedback.data),
    .rd_en      (up_rd),
    .rd_data    (up_data),
    .rd_valid   (up_valid),
    .empty      (up_empty),
    .free_count ()
  );

  // ---------------------------------------------------------------------------
  // command output
  // ---------------------------------------------------------------------------
  cmd_dispatch #(.hold_cycles(hold_cycles)) u_dispatch (
    .clk_100    (clk_100),
    .reset      (reset),
    .fifo_empty (down_empty),
    .fifo_word  ({down_valid, down_data}),
    .fifo_rd    (down_rd),
    .cmd        (cmd),
    .bram       (bram)
  );

endmodule

// File: test/tb_usb_cmd_bridge.sv
// usb command bridge testbench
module tb_usb_cmd_bridge;

  localparam int HOLD       = 40;
  localparam int ROWS       = 12;
  localparam int PASSES     = 2;
  // cycles per table row, room for a read, a write and in_ready stalls
  localparam int ROW_BUDGET = 40;
  localparam int CLK_PERIOD = 10;
  localparam int TIMEOUT    = (ROWS * PASSES * ROW_BUDGET + 100) * CLK_PERIOD;

  // one stimulus row
  typedef struct packed {
    logic [31:0] out_word;
    logic [31:0] fb_word;
    logic        send_fb;
  } row_t;

  logic                              clk_100;
  logic                              reset;
  usb_bridge_pkg::fx3_flags_t        flags;
  usb_bridge_pkg::fx3_ctrl_t         ctrl;
  wire  [usb_bridge_pkg::WORD_W-1:0] fdata;
  usb_bridge_pkg::word_strobe_t      feedback;
  usb_bridge_pkg::word_strobe_t      cmd;
  usb_bridge_pkg::word_strobe_t      bram;

  // host side of the bus
  logic        host_drive;
  logic [31:0] host_data;
  logic [31:0] out_q [$];
  // words still owed by the DUT
  logic [31:0] cmd_exp [$];
  logic [31:0] fb_exp [$];
  row_t        rows [ROWS];

  int          cycle;
  int          value_errors;
  int          other_errors;
  logic        bram_due;
  logic [31:0] bram_exp;
  logic        pkt_due;
  logic        stall_on;
  int unsigned rnd;

  assign fdata = host_drive ? host_data : 'z;

  usb_cmd_bridge #(.hold_cycles(HOLD)) u_usb_cmd_bridge (
    .clk_100  (clk_100),
    .reset    (reset),
    .flags    (flags),
    .ctrl     (ctrl),
    .fdata    (fdata),
    .feedback (feedback),
    .cmd      (cmd),
    .bram     (bram)
  );

  initial begin
    clk_100 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_100 = ~clk_100;
  end

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      value_errors = value_errors + 1;
      $display("Error: %s is %h, expected %h (cycle %0d)", name, got, exp, cycle);
    end
  endtask

  task automatic note_failure(input string what);
    other_errors = other_errors + 1;
    $display("%s (cycle %0d)", what, cycle);
  endtask

  // idle bus and quiet outputs straight out of reset
  task automatic check_reset_state();
    check_value("ctrl.slcs_n", ctrl.slcs_n, 1'b1);
    check_value("ctrl.sloe_n", ctrl.sloe_n, 1'b1);
    check_value("ctrl.slrd_n", ctrl.slrd_n, 1'b1);
    check_value("ctrl.slwr_n", ctrl.slwr_n, 1'b1);
    check_value("ctrl.pktend_n", ctrl.pktend_n, 1'b1);
    check_value("cmd.valid", cmd.valid, 1'b0);
    check_value("bram.valid", bram.valid, 1'b0);
    check_value("fdata", fdata, 32'hzzzz_zzzz);
  endtask

  // ---------------------------------------------------------------------------
  // one clock of monitor and host pin model, run at the falling edge
  // ---------------------------------------------------------------------------
  task automatic step_cycle();
    logic [31:0] word;
    @(negedge clk_100);
    cycle = cycle + 1;
    // bram copy owed from last cycle's command
    check_value("bram.valid", bram.valid, bram_due);
    if (bram_due) begin
      check_value("bram.data", bram.data, bram_exp);
    end else if (cycle <= HOLD) begin
      check_value("bram.data", bram.data, 32'h0);
    end
    bram_due = 1'b0;
    if (cmd.valid) begin
      if (cmd_exp.size() == 0) begin
        note_failure("command strobe with no command outstanding");
      end else begin
        word = cmd_exp.pop_front();
        check_value("cmd.data", cmd.data, word);
        // past the hold-off the copy follows with halves exchanged
        if (cycle >= HOLD) begin
          bram_due = 1'b1;
          bram_exp = {word[15:0], word[31:16]};
        end
      end
    end
    // packet end only right after the write that emptied the upload side
    check_value("ctrl.pktend_n", ctrl.pktend_n, !pkt_due);
    pkt_due = 1'b0;
    if (!ctrl.slrd_n && !ctrl.slwr_n) begin
      note_failure("slrd_n and slwr_n were low in the same cycle");
    end
    if (!ctrl.slwr_n) begin
      check_value("ctrl.faddr", ctrl.faddr, usb_bridge_pkg::IN_EP_ADDR);
      if (fb_exp.size() == 0) begin
        note_failure("write strobe with no feedback pending");
      end else begin
        word = fb_exp.pop_front();
        check_value("fdata", fdata, word);
        pkt_due = (fb_exp.size() == 0);
      end
    end
    if (!ctrl.slrd_n) begin
      check_value("ctrl.faddr", ctrl.faddr, usb_bridge_pkg::OUT_EP_ADDR);
      if (out_q.size() == 0) begin
        note_failure("read strobe while the OUT endpoint was empty");
      end else begin
        host_data = out_q.pop_front();
      end
    end
    // host owns the bus while output enable is low
    host_drive      = !ctrl.sloe_n;
    flags.out_ready = (out_q.size() != 0);
    flags.in_ready  = stall_on ? (($urandom % 4) != 0) : 1'b1;
    feedback        = '0;
  endtask

  // out word, feedback word, send feedback
  task automatic load_table();
    rows[0]  = {32'h1234_5678, 32'hfb00_0001, 1'b1};
    rows[1]  = {32'h0000_ffff, 32'hfb00_0002, 1'b0};
    rows[2]  = {32'hdead_beef, 32'hfb00_0003, 1'b1};
    rows[3]  = {32'ha5a5_5a5a, 32'hfb00_0004, 1'b1};
    rows[4]  = {32'h8000_0001, 32'hfb00_0005, 1'b0};
    rows[5]  = {32'h0102_0304, 32'hfb00_0006, 1'b1};
    rows[6]  = {32'hcafe_f00d, 32'hfb00_0007, 1'b1};
    rows[7]  = {32'hffff_0000, 32'hfb00_0008, 1'b0};
    rows[8]  = {32'h1357_9bdf, 32'hfb00_0009, 1'b1};
    rows[9]  = {32'h2468_ace0, 32'hfb00_000a, 1'b1};
    rows[10] = {32'h0f0f_f0f0, 32'hfb00_000b, 1'b0};
    rows[11] = {32'h7654_3210, 32'hfb00_000c, 1'b1};
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    logic [31:0] word;
    rnd          = $urandom(32'h6179);
    reset        = 1'b1;
    flags        = '0;
    feedback     = '0;
    host_drive   = 1'b0;
    host_data    = '0;
    cycle        = 0;
    value_errors = 0;
    other_errors = 0;
    bram_due     = 1'b0;
    bram_exp     = '0;
    pkt_due      = 1'b0;
    stall_on     = 1'b0;
    load_table();
    repeat (3) @(negedge clk_100);
    check_reset_state();
    reset = 1'b0;
    // second pass inverts the words and stalls the IN side at random
    for (int pass = 0; pass < PASSES; pass++) begin
      stall_on = (pass == 1);
      for (int i = 0; i < ROWS; i++) begin
        step_cycle();
        word = (pass == 1) ? ~rows[i].out_word : rows[i].out_word;
        out_q.push_back(word);
        cmd_exp.push_back(word);
        flags.out_ready = 1'b1;
        if (rows[i].send_fb) begin
          word          = (pass == 1) ? ~rows[i].fb_word : rows[i].fb_word;
          feedback.valid = 1'b1;
          feedback.data  = word;
          fb_exp.push_back(word);
        end
        repeat ((pass == 0) ? 3 : 1) step_cycle();
      end
      // let both streams run dry
      while (out_q.size() != 0 || cmd_exp.size() != 0 || fb_exp.size() != 0) begin
        step_cycle();
      end
      repeat (4) step_cycle();
    end
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog, bound scales with the table length
  initial begin
    #(TIMEOUT);
    $display("run did not finish within %0d time units", TIMEOUT);
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: tb.f
rtl/usb_bridge_pkg.sv
rtl/word_fifo.sv
rtl/fx3_slave_fifo.sv
rtl/cmd_dispatch.sv
rtl/usb_cmd_bridge.sv
test/tb_usb_cmd_bridge.sv

// File: Bender.yml
package:
  name: usb_cmd_bridge

sources:
  - files:
      - rtl/usb_bridge_pkg.sv
      - rtl/word_fifo.sv
      - rtl/fx3_slave_fifo.sv
      - rtl/cmd_dispatch.sv
      - rtl/usb_cmd_bridge.sv
  - target: test
    files:
      - test/tb_usb_cmd_bridge.sv
